// ==== design/im2col_addr_calc.sv ====
// im2col source address calculator
// Four-stage index pipeline, byte source pointer and second-dimension increment
`timescale 1ns/10ps

module im2col_addr_calc
  import im2col_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  dim_t                    batch_cnt_i,
  input  dim_t                    im_c_i,
  input  dim_t                    num_ch_i,
  input  ptr_t                    ih_i,
  input  ptr_t                    iw_i,
  input  ptr_t                    src_ptr_i,
  input  dim_t                    h_offset_i,
  input  dim_t                    w_offset_i,
  input  dim_t                    pad_top_i,
  input  dim_t                    pad_left_i,
  input  dim_t                    n_zeros_top_i,
  input  dim_t                    n_zeros_left_i,
  input  size_t                   size_d1_i,
  input  logic [LOG_STRIDE_W-1:0] log_stride_d1_i,
  input  logic [LOG_STRIDE_W-1:0] log_stride_d2_i,
  output ptr_t                    src_ptr_o,
  output inc_t                    in_inc_d2_o
);

  dim_t im_row, im_col;
  ptr_t row_ext, col_ext;
  ptr_t idx1_q, idx2_q, idx3_q, idx4_q;
  ptr_t index;
  ptr_t inc_full;

  // Row and column may fall into the padding, so they are signed
  assign im_row  = h_offset_i - pad_top_i;
  assign im_col  = w_offset_i - pad_left_i;
  assign row_ext = {{(PTR_W-DIM_W){im_row[DIM_W-1]}}, im_row};
  assign col_ext = {{(PTR_W-DIM_W){im_col[DIM_W-1]}}, im_col};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      idx1_q <= '0;
      idx2_q <= '0;
      idx3_q <= '0;
      idx4_q <= '0;
    end else begin
      idx1_q <= ptr_t'(batch_cnt_i) * ptr_t'(num_ch_i) + ptr_t'(im_c_i);
      idx2_q <= idx1_q * ih_i;
      idx3_q <= idx2_q + row_ext + (ptr_t'(n_zeros_top_i) << log_stride_d2_i);
      idx4_q <= idx3_q * iw_i + col_ext;
    end
  end

  assign index     = idx4_q + (ptr_t'(n_zeros_left_i) << log_stride_d1_i);
  // Elements are 32-bit words
  assign src_ptr_o = src_ptr_i + (index << 2);

  assign inc_full    = (iw_i << log_stride_d2_i)
                     - ((ptr_t'(size_d1_i) - 1'b1) << log_stride_d1_i);
  assign in_inc_d2_o = inc_full[INC_W-1:0];

endmodule

// ==== design/im2col_cfg_regs.sv ====
// im2col configuration registers
// Holds the convolution geometry, written one word at a time by strobe
`timescale 1ns/10ps

module im2col_cfg_regs
  import im2col_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cfg_we_i,
  input  cfg_addr_e               cfg_addr_i,
  input  ptr_t                    cfg_wdata_i,
  input  logic                    start_i,
  output ptr_t                    src_ptr_o,
  output ptr_t                    dst_ptr_o,
  output ptr_t                    ih_o,
  output ptr_t                    iw_o,
  output dim_t                    fh_o,
  output dim_t                    fw_o,
  output dim_t                    num_ch_o,
  output dim_t                    batch_o,
  output dim_t                    pad_top_o,
  output dim_t                    pad_bottom_o,
  output dim_t                    pad_left_o,
  output dim_t                    pad_right_o,
  output dim_t                    adpt_pad_bottom_o,
  output dim_t                    adpt_pad_right_o,
  output size_t                   ch_col_o,
  output size_t                   n_patches_h_o,
  output size_t                   n_patches_w_o,
  output logic [LOG_STRIDE_W-1:0] log_stride_d1_o,
  output logic [LOG_STRIDE_W-1:0] log_stride_d2_o
);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_ptr_o         <= '0;
      dst_ptr_o         <= '0;
      ih_o              <= '0;
      iw_o              <= '0;
      fh_o              <= '0;
      fw_o              <= '0;
      num_ch_o          <= '0;
      batch_o           <= '0;
      pad_top_o         <= '0;
      pad_bottom_o      <= '0;
      pad_left_o        <= '0;
      pad_right_o       <= '0;
      adpt_pad_bottom_o <= '0;
      adpt_pad_right_o  <= '0;
      ch_col_o          <= '0;
      n_patches_h_o     <= '0;
      n_patches_w_o     <= '0;
      log_stride_d1_o   <= '0;
      log_stride_d2_o   <= '0;
    end else if (cfg_we_i) begin
      // Narrow registers keep only the low bits of the write data
      unique case (cfg_addr_i)
        SRC_PTR:         src_ptr_o         <= cfg_wdata_i;
        DST_PTR:         dst_ptr_o         <= cfg_wdata_i;
        IH:              ih_o              <= cfg_wdata_i;
        IW:              iw_o              <= cfg_wdata_i;
        FH:              fh_o              <= cfg_wdata_i[DIM_W-1:0];
        FW:              fw_o              <= cfg_wdata_i[DIM_W-1:0];
        NUM_CH:          num_ch_o          <= cfg_wdata_i[DIM_W-1:0];
        BATCH:           batch_o           <= cfg_wdata_i[DIM_W-1:0];
        CH_COL:          ch_col_o          <= cfg_wdata_i[SIZE_W-1:0];
        N_PATCHES_H:     n_patches_h_o     <= cfg_wdata_i[SIZE_W-1:0];
        N_PATCHES_W:     n_patches_w_o     <= cfg_wdata_i[SIZE_W-1:0];
        PAD_TOP:         pad_top_o         <= cfg_wdata_i[DIM_W-1:0];
        PAD_BOTTOM:      pad_bottom_o      <= cfg_wdata_i[DIM_W-1:0];
        PAD_LEFT:        pad_left_o        <= cfg_wdata_i[DIM_W-1:0];
        PAD_RIGHT:       pad_right_o       <= cfg_wdata_i[DIM_W-1:0];
        ADPT_PAD_BOTTOM: adpt_pad_bottom_o <= cfg_wdata_i[DIM_W-1:0];
        ADPT_PAD_RIGHT:  adpt_pad_right_o  <= cfg_wdata_i[DIM_W-1:0];
        LOG_STRIDE_D1:   log_stride_d1_o   <= cfg_wdata_i[LOG_STRIDE_W-1:0];
        LOG_STRIDE_D2:   log_stride_d2_o   <= cfg_wdata_i[LOG_STRIDE_W-1:0];
        default: ;
      endcase
    end
  end

  // The offset counters in the sequencer wrap on fw and fh
  a_filter_nonzero: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    start_i |-> (fw_o != '0) && (fh_o != '0)
  ) else $error("Start accepted with a zero filter dimension");

endmodule

// ==== design/im2col_loop_ctrl.sv ====
// im2col sequencer FSM
// Walks filter offsets, channels and batch images and times each descriptor push
`timescale 1ns/10ps

module im2col_loop_ctrl
  import im2col_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  start_i,
  input  logic  fifo_full_i,
  input  dim_t  fw_i,
  input  dim_t  fh_i,
  input  dim_t  batch_i,
  input  size_t ch_col_i,
  input  ptr_t  dst_ptr_i,
  input  size_t n_patches_h_i,
  input  size_t n_patches_w_i,
  output dim_t  w_offset_o,
  output dim_t  h_offset_o,
  output dim_t  im_c_o,
  output dim_t  batch_cnt_o,
  output logic  zeros_p1_en_o,
  output logic  zeros_p2_en_o,
  output logic  zeros_clr_o,
  output logic  fifo_push_o,
  output logic  param_done_o,
  output ptr_t  out_ptr_o
);

  seq_state_e state_q, state_d;
  size_t      k_q;
  size_t      c_cnt_q;
  dim_t       h_cnt_q;
  dim_t       w_offset_q, h_offset_q, im_c_q, batch_cnt_q;
  ptr_t       out_ptr_q, out_inc_q;
  logic       done_q;
  logic       start_ok, batch_last, k_last;
  size_t      fwh;

  assign start_ok   = (state_q == IDLE) && start_i;
  assign batch_last = batch_cnt_q == batch_i - 1'b1;
  assign k_last     = k_q == ch_col_i - 1'b1;
  assign fwh        = size_t'(fw_i) * size_t'(fh_i);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = PRECOMP;
        end
      end
      PRECOMP:   state_d = COND_EVAL;
      // Only the first pair after start runs the full zero phases
      COND_EVAL: begin
        if (k_q == '0 && batch_cnt_q == '0) begin
          state_d = ZEROS_1;
        end else begin
          state_d = INDEX_1;
        end
      end
      ZEROS_1:   state_d = ZEROS_2;
      ZEROS_2:   state_d = ZEROS_3;
      ZEROS_3:   state_d = INDEX_1;
      INDEX_1:   state_d = INDEX_2;
      INDEX_2:   state_d = INDEX_3;
      INDEX_3: begin
        if (!fifo_full_i) begin
          state_d = PUSH;
        end
      end
      PUSH:      state_d = OUT_PTR_UPDATE;
      OUT_PTR_UPDATE: begin
        state_d = batch_last ? OFFSET_UPDATE : COND_EVAL;
      end
      OFFSET_UPDATE: begin
        state_d = k_last ? IDLE : COND_EVAL;
      end
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start_ok) begin
        done_q <= 1'b0;
      end else if (state_q == OFFSET_UPDATE) begin
        done_q <= k_last;
      end
    end
  end

  // Batch image and channel-column counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      batch_cnt_q <= '0;
      k_q         <= '0;
    end else if (start_ok) begin
      batch_cnt_q <= '0;
      k_q         <= '0;
    end else if (state_q == OUT_PTR_UPDATE) begin
      batch_cnt_q <= batch_cnt_q + 1'b1;
    end else if (state_q == OFFSET_UPDATE) begin
      batch_cnt_q <= '0;
      k_q         <= k_q + 1'b1;
    end
  end

  // Filter offsets: w every step, h every fw steps, channel every fw*fh steps
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_offset_q <= '0;
      h_offset_q <= '0;
      h_cnt_q    <= '0;
      im_c_q     <= '0;
      c_cnt_q    <= '0;
    end else if (start_ok) begin
      w_offset_q <= '0;
      h_offset_q <= '0;
      h_cnt_q    <= '0;
      im_c_q     <= '0;
      c_cnt_q    <= '0;
    end else if (state_q == OFFSET_UPDATE) begin
      w_offset_q <= (w_offset_q == fw_i - 1'b1) ? '0 : w_offset_q + 1'b1;
      if (h_cnt_q == fw_i - 1'b1) begin
        h_cnt_q    <= '0;
        h_offset_q <= (h_offset_q == fh_i - 1'b1) ? '0 : h_offset_q + 1'b1;
      end else begin
        h_cnt_q <= h_cnt_q + 1'b1;
      end
      if (c_cnt_q == fwh - 1'b1) begin
        c_cnt_q <= '0;
        im_c_q  <= im_c_q + 1'b1;
      end else begin
        c_cnt_q <= c_cnt_q + 1'b1;
      end
    end
  end

  // Output pointer step is one full patch plane of 32-bit words
  always_ff @(posedge clk_i) begin
    if (state_q == PRECOMP) begin
      out_inc_q <= (ptr_t'(n_patches_h_i) * ptr_t'(n_patches_w_i)) << 2;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_ptr_q <= '0;
    end else if (start_ok) begin
      out_ptr_q <= dst_ptr_i;
    end else if (state_q == OUT_PTR_UPDATE) begin
      out_ptr_q <= out_ptr_q + out_inc_q;
    end
  end

  // Phase one reads the new offsets, phase two follows a cycle later
  assign zeros_clr_o   = state_q == PRECOMP;
  assign zeros_p1_en_o = state_q inside {COND_EVAL, ZEROS_1};
  assign zeros_p2_en_o = state_q inside {ZEROS_2, ZEROS_3, INDEX_1};
  assign fifo_push_o   = state_q == PUSH;
  assign param_done_o  = done_q;
  assign w_offset_o    = w_offset_q;
  assign h_offset_o    = h_offset_q;
  assign im_c_o        = im_c_q;
  assign batch_cnt_o   = batch_cnt_q;
  assign out_ptr_o     = out_ptr_q;

  a_no_push_when_full: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    fifo_push_o |-> !fifo_full_i
  ) else $error("Descriptor pushed into a full FIFO");

endmodule

// ==== design/im2col_pad_calc.sv ====
// im2col zero-padding calculator
// Two-phase edge zero counts with power-of-two strides, and the transfer sizes
`timescale 1ns/10ps

module im2col_pad_calc
  import im2col_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    zeros_p1_en_i,
  input  logic                    zeros_p2_en_i,
  input  logic                    zeros_clr_i,
  input  dim_t                    w_offset_i,
  input  dim_t                    h_offset_i,
  input  dim_t                    fw_i,
  input  dim_t                    fh_i,
  input  dim_t                    pad_top_i,
  input  dim_t                    pad_bottom_i,
  input  dim_t                    pad_left_i,
  input  dim_t                    pad_right_i,
  input  dim_t                    adpt_pad_bottom_i,
  input  dim_t                    adpt_pad_right_i,
  input  logic [LOG_STRIDE_W-1:0] log_stride_d1_i,
  input  logic [LOG_STRIDE_W-1:0] log_stride_d2_i,
  input  size_t                   n_patches_h_i,
  input  size_t                   n_patches_w_i,
  output dim_t                    n_zeros_top_o,
  output dim_t                    n_zeros_bottom_o,
  output dim_t                    n_zeros_left_o,
  output dim_t                    n_zeros_right_o,
  output size_t                   size_d1_o,
  output size_t                   size_d2_o
);

  dim_t fw_rem, fh_rem;
  dim_t fw_rem_q, fh_rem_q;
  dim_t left_diff_q, top_diff_q, right_diff_q, bottom_diff_q;

  // Ceiling division by 2^s: shift, plus one if any remainder bit is set
  function automatic dim_t ceil_shift(input dim_t diff, input logic [LOG_STRIDE_W-1:0] s);
    dim_t mask;
    mask = ~({DIM_W{1'b1}} << s);
    return (diff >> s) + dim_t'(|(diff & mask));
  endfunction

  assign fw_rem = fw_i - 1'b1 - w_offset_i;
  assign fh_rem = fh_i - 1'b1 - h_offset_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fw_rem_q      <= '0;
      fh_rem_q      <= '0;
      left_diff_q   <= '0;
      top_diff_q    <= '0;
      right_diff_q  <= '0;
      bottom_diff_q <= '0;
    end else if (zeros_clr_i) begin
      fw_rem_q      <= '0;
      fh_rem_q      <= '0;
      left_diff_q   <= '0;
      top_diff_q    <= '0;
      right_diff_q  <= '0;
      bottom_diff_q <= '0;
    end else if (zeros_p1_en_i) begin
      fw_rem_q      <= fw_rem;
      fh_rem_q      <= fh_rem;
      left_diff_q   <= pad_left_i - w_offset_i;
      top_diff_q    <= pad_top_i - h_offset_i;
      right_diff_q  <= adpt_pad_right_i - fw_rem;
      bottom_diff_q <= adpt_pad_bottom_i - fh_rem;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      n_zeros_top_o    <= '0;
      n_zeros_bottom_o <= '0;
      n_zeros_left_o   <= '0;
      n_zeros_right_o  <= '0;
    end else if (zeros_clr_i) begin
      n_zeros_top_o    <= '0;
      n_zeros_bottom_o <= '0;
      n_zeros_left_o   <= '0;
      n_zeros_right_o  <= '0;
    end else if (zeros_p2_en_i) begin
      n_zeros_left_o <= (w_offset_i >= pad_left_i) ? '0
                      : ceil_shift(left_diff_q, log_stride_d1_i);
      n_zeros_top_o  <= (h_offset_i >= pad_top_i) ? '0
                      : ceil_shift(top_diff_q, log_stride_d2_i);
      // Right and bottom only pad when the adaptive amount is set
      n_zeros_right_o  <= (fw_rem_q >= pad_right_i || adpt_pad_right_i == '0) ? '0
                        : ceil_shift(right_diff_q, log_stride_d1_i);
      n_zeros_bottom_o <= (fh_rem_q >= pad_bottom_i || adpt_pad_bottom_i == '0) ? '0
                        : ceil_shift(bottom_diff_q, log_stride_d2_i);
    end
  end

  assign size_d1_o = n_patches_w_i - size_t'(n_zeros_left_o) - size_t'(n_zeros_right_o);
  assign size_d2_o = n_patches_h_i - size_t'(n_zeros_top_o) - size_t'(n_zeros_bottom_o);

endmodule

// ==== design/im2col_param_top.sv ====
// im2col parameter sequencer top level
// Register block beside the sequencer FSM, the padding and the address datapaths
`timescale 1ns/10ps

module im2col_param_top
  import im2col_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      cfg_we_i,
  input  cfg_addr_e cfg_addr_i,
  input  ptr_t      cfg_wdata_i,
  input  logic      start_i,
  input  logic      fifo_full_i,
  output logic      fifo_push_o,
  output logic      param_done_o,
  output ptr_t      src_ptr_o,
  output ptr_t      dst_ptr_o,
  output inc_t      in_inc_d2_o,
  output dim_t      n_zeros_top_o,
  output dim_t      n_zeros_bottom_o,
  output dim_t      n_zeros_left_o,
  output dim_t      n_zeros_right_o,
  output size_t     size_d1_o,
  output size_t     size_d2_o
);

  ptr_t                    src_ptr, cfg_dst_ptr, ih, iw;
  dim_t                    fh, fw, num_ch, batch;
  dim_t                    pad_top, pad_bottom, pad_left, pad_right;
  dim_t                    adpt_pad_bottom, adpt_pad_right;
  size_t                   ch_col, n_patches_h, n_patches_w;
  logic [LOG_STRIDE_W-1:0] log_stride_d1, log_stride_d2;
  dim_t                    w_offset, h_offset, im_c, batch_cnt;
  logic                    zeros_p1_en, zeros_p2_en, zeros_clr;

  im2col_cfg_regs i_cfg_regs (
    .clk_i,
    .rst_ni,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .start_i,
    .src_ptr_o         (src_ptr),
    .dst_ptr_o         (cfg_dst_ptr),
    .ih_o              (ih),
    .iw_o              (iw),
    .fh_o              (fh),
    .fw_o              (fw),
    .num_ch_o          (num_ch),
    .batch_o           (batch),
    .pad_top_o         (pad_top),
    .pad_bottom_o      (pad_bottom),
    .pad_left_o        (pad_left),
    .pad_right_o       (pad_right),
    .adpt_pad_bottom_o (adpt_pad_bottom),
    .adpt_pad_right_o  (adpt_pad_right),
    .ch_col_o          (ch_col),
    .n_patches_h_o     (n_patches_h),
    .n_patches_w_o     (n_patches_w),
    .log_stride_d1_o   (log_stride_d1),
    .log_stride_d2_o   (log_stride_d2)
  );

  im2col_loop_ctrl i_loop_ctrl (
    .clk_i,
    .rst_ni,
    .start_i,
    .fifo_full_i,
    .fw_i          (fw),
    .fh_i          (fh),
    .batch_i       (batch),
    .ch_col_i      (ch_col),
    .dst_ptr_i     (cfg_dst_ptr),
    .n_patches_h_i (n_patches_h),
    .n_patches_w_i (n_patches_w),
    .w_offset_o    (w_offset),
    .h_offset_o    (h_offset),
    .im_c_o        (im_c),
    .batch_cnt_o   (batch_cnt),
    .zeros_p1_en_o (zeros_p1_en),
    .zeros_p2_en_o (zeros_p2_en),
    .zeros_clr_o   (zeros_clr),
    .fifo_push_o,
    .param_done_o,
    .out_ptr_o     (dst_ptr_o)
  );

  im2col_pad_calc i_pad_calc (
    .clk_i,
    .rst_ni,
    .zeros_p1_en_i     (zeros_p1_en),
    .zeros_p2_en_i     (zeros_p2_en),
    .zeros_clr_i       (zeros_clr),
    .w_offset_i        (w_offset),
    .h_offset_i        (h_offset),
    .fw_i              (fw),
    .fh_i              (fh),
    .pad_top_i         (pad_top),
    .pad_bottom_i      (pad_bottom),
    .pad_left_i        (pad_left),
    .pad_right_i       (pad_right),
    .adpt_pad_bottom_i (adpt_pad_bottom),
    .adpt_pad_right_i  (adpt_pad_right),
    .log_stride_d1_i   (log_stride_d1),
    .log_stride_d2_i   (log_stride_d2),
    .n_patches_h_i     (n_patches_h),
    .n_patches_w_i     (n_patches_w),
    .n_zeros_top_o,
    .n_zeros_bottom_o,
    .n_zeros_left_o,
    .n_zeros_right_o,
    .size_d1_o,
    .size_d2_o
  );

  im2col_addr_calc i_addr_calc (
    .clk_i,
    .rst_ni,
    .batch_cnt_i     (batch_cnt),
    .im_c_i          (im_c),
    .num_ch_i        (num_ch),
    .ih_i            (ih),
    .iw_i            (iw),
    .src_ptr_i       (src_ptr),
    .h_offset_i      (h_offset),
    .w_offset_i      (w_offset),
    .pad_top_i       (pad_top),
    .pad_left_i      (pad_left),
    .n_zeros_top_i   (n_zeros_top_o),
    .n_zeros_left_i  (n_zeros_left_o),
    .size_d1_i       (size_d1_o),
    .log_stride_d1_i (log_stride_d1),
    .log_stride_d2_i (log_stride_d2),
    .src_ptr_o,
    .in_inc_d2_o
  );

endmodule

// ==== design/im2col_pkg.sv ====
// im2col parameter sequencer shared definitions
// Widths, datapath types, register map and sequencer states
package im2col_pkg;

  localparam int DIM_W        = 8;
  localparam int SIZE_W       = 16;
  localparam int PTR_W        = 32;
  localparam int INC_W        = 23;
  localparam int LOG_STRIDE_W = 4;
  localparam int CFG_ADDR_W   = 5;

  typedef logic [DIM_W-1:0]  dim_t;
  typedef logic [SIZE_W-1:0] size_t;
  typedef logic [PTR_W-1:0]  ptr_t;
  typedef logic [INC_W-1:0]  inc_t;

  // Configuration register map, one word per entry
  typedef enum logic [CFG_ADDR_W-1:0] {
    SRC_PTR,
    DST_PTR,
    IH,
    IW,
    FH,
    FW,
    NUM_CH,
    BATCH,
    CH_COL,
    N_PATCHES_H,
    N_PATCHES_W,
    PAD_TOP,
    PAD_BOTTOM,
    PAD_LEFT,
    PAD_RIGHT,
    ADPT_PAD_BOTTOM,
    ADPT_PAD_RIGHT,
    LOG_STRIDE_D1,
    LOG_STRIDE_D2
  } cfg_addr_e;

  typedef enum logic [3:0] {
    IDLE,
    PRECOMP,
    COND_EVAL,
    ZEROS_1,
    ZEROS_2,
    ZEROS_3,
    INDEX_1,
    INDEX_2,
    INDEX_3,
    PUSH,
    OUT_PTR_UPDATE,
    OFFSET_UPDATE
  } seq_state_e;

endpackage

// ==== testbench/tb_clk_gen.sv ====
// Testbench clock and reset source
// 20 ns clock, active-low reset held for the first 5 cycles
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #10 clk_o = ~clk_o;
    end
  end

  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #2 rst_no = 1'b1;
  end

endmodule

// ==== testbench/tb_im2col_param.sv ====
// im2col parameter sequencer testbench
// Directed runs against a descriptor reference model, with random FIFO back-pressure
`timescale 1ns/10ps

module tb_im2col_param
  import im2col_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int PUSH_TIMEOUT  = 100;
  localparam int DONE_TIMEOUT  = 20;
  localparam int RESET_TIMEOUT = 20;
  localparam int FIRST_LATENCY = 9;
  localparam int DONE_LATENCY  = 3;

  logic      clk_i, rst_ni;
  logic      cfg_we_i, start_i, fifo_full_i;
  cfg_addr_e cfg_addr_i;
  ptr_t      cfg_wdata_i;
  logic      fifo_push_o, param_done_o;
  ptr_t      src_ptr_o, dst_ptr_o;
  inc_t      in_inc_d2_o;
  dim_t      n_zeros_top_o, n_zeros_bottom_o, n_zeros_left_o, n_zeros_right_o;
  size_t     size_d1_o, size_d2_o;

  int     value_errs = 0;
  int     other_errs = 0;
  int     push_count = 0;
  int     stall_left = 0;
  logic   stall_en = 1'b0;
  integer seed = 32'h4afb7870;

  // Model copy of the programmed geometry
  int cfg_src, cfg_dst, cfg_ih, cfg_iw, cfg_fh, cfg_fw, cfg_nch, cfg_batch, cfg_chcol;
  int cfg_nph, cfg_npw, cfg_pt, cfg_pb, cfg_pl, cfg_pr, cfg_apb, cfg_apr, cfg_s1, cfg_s2;

  ptr_t  exp_src, exp_dst;
  inc_t  exp_inc;
  dim_t  exp_top, exp_bottom, exp_left, exp_right;
  size_t exp_sd1, exp_sd2;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  im2col_param_top i_im2col_param_top (
    .clk_i,
    .rst_ni,
    .cfg_we_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .start_i,
    .fifo_full_i,
    .fifo_push_o,
    .param_done_o,
    .src_ptr_o,
    .dst_ptr_o,
    .in_inc_d2_o,
    .n_zeros_top_o,
    .n_zeros_bottom_o,
    .n_zeros_left_o,
    .n_zeros_right_o,
    .size_d1_o,
    .size_d2_o
  );

  // FIFO model: a push may fill the FIFO for a random number of cycles
  always @(posedge clk_i) begin
    #2;
    if (stall_left > 0) begin
      fifo_full_i = 1'b1;
      stall_left--;
    end else begin
      fifo_full_i = 1'b0;
    end
    if (fifo_push_o && stall_en) begin
      stall_left = $unsigned($random(seed)) % 12;
    end
  end

  always @(negedge clk_i) begin
    if (fifo_push_o) begin
      push_count++;
      if (fifo_full_i) begin
        $display("Descriptor pushed while the FIFO reported full at %0t", $time);
        other_errs++;
      end
    end
  end

  task automatic finish_run();
    $display("Value mismatches: %0d, other failures: %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic check_ptr(input string name, input ptr_t got, input ptr_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_dim(input string name, input dim_t got, input dim_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_size(input string name, input size_t got, input size_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_inc(input string name, input inc_t got, input inc_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
      value_errs++;
    end
  endtask

  function automatic int ceil_div(input int num, input int log_div);
    int d;
    d = 1 << log_div;
    return (num + d - 1) / d;
  endfunction

  task automatic write_reg(input cfg_addr_e addr, input int data);
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = ptr_t'(data);
    @(posedge clk_i);
    #2;
    cfg_we_i = 1'b0;
  endtask

  task automatic configure(input int src, input int dst, input int ih, input int iw,
                           input int fh, input int fw, input int nch, input int batch,
                           input int pt, input int pb, input int pl, input int pr,
                           input int apb, input int apr, input int s1, input int s2);
    cfg_src = src;
    cfg_dst = dst;
    cfg_ih = ih;
    cfg_iw = iw;
    cfg_fh = fh;
    cfg_fw = fw;
    cfg_nch = nch;
    cfg_batch = batch;
    cfg_pt = pt;
    cfg_pb = pb;
    cfg_pl = pl;
    cfg_pr = pr;
    cfg_apb = apb;
    cfg_apr = apr;
    cfg_s1 = s1;
    cfg_s2 = s2;
    cfg_chcol = fw * fh * nch;
    cfg_nph = ((ih + pt + pb - fh) >> s2) + 1;
    cfg_npw = ((iw + pl + pr - fw) >> s1) + 1;
    write_reg(SRC_PTR, cfg_src);
    write_reg(DST_PTR, cfg_dst);
    write_reg(IH, cfg_ih);
    write_reg(IW, cfg_iw);
    write_reg(FH, cfg_fh);
    write_reg(FW, cfg_fw);
    write_reg(NUM_CH, cfg_nch);
    write_reg(BATCH, cfg_batch);
    write_reg(CH_COL, cfg_chcol);
    write_reg(N_PATCHES_H, cfg_nph);
    write_reg(N_PATCHES_W, cfg_npw);
    write_reg(PAD_TOP, cfg_pt);
    write_reg(PAD_BOTTOM, cfg_pb);
    write_reg(PAD_LEFT, cfg_pl);
    write_reg(PAD_RIGHT, cfg_pr);
    write_reg(ADPT_PAD_BOTTOM, cfg_apb);
    write_reg(ADPT_PAD_RIGHT, cfg_apr);
    write_reg(LOG_STRIDE_D1, cfg_s1);
    write_reg(LOG_STRIDE_D2, cfg_s2);
  endtask

  // Reference descriptor for filter position k, batch image b, descriptor number num
  task automatic expect_desc(input int k, input int b, input int num);
    int w, h, c, l, r, t, bt, sd1, sd2, idx, inc;
    w = k % cfg_fw;
    h = (k / cfg_fw) % cfg_fh;
    c = k / (cfg_fw * cfg_fh);
    l = (w >= cfg_pl) ? 0 : ceil_div(cfg_pl - w, cfg_s1);
    t = (h >= cfg_pt) ? 0 : ceil_div(cfg_pt - h, cfg_s2);
    r = (cfg_fw - 1 - w >= cfg_pr || cfg_apr == 0) ? 0
      : ceil_div(cfg_apr - (cfg_fw - 1 - w), cfg_s1);
    bt = (cfg_fh - 1 - h >= cfg_pb || cfg_apb == 0) ? 0
       : ceil_div(cfg_apb - (cfg_fh - 1 - h), cfg_s2);
    sd1 = cfg_npw - l - r;
    sd2 = cfg_nph - t - bt;
    idx = ((b * cfg_nch + c) * cfg_ih + h - cfg_pt + t * (1 << cfg_s2)) * cfg_iw
        + w - cfg_pl + l * (1 << cfg_s1);
    inc = cfg_iw * (1 << cfg_s2) - (sd1 - 1) * (1 << cfg_s1);
    exp_src = ptr_t'(cfg_src + 4 * idx);
    exp_dst = ptr_t'(cfg_dst + 4 * cfg_nph * cfg_npw * num);
    exp_inc = inc[INC_W-1:0];
    exp_left = dim_t'(l);
    exp_right = dim_t'(r);
    exp_top = dim_t'(t);
    exp_bottom = dim_t'(bt);
    exp_sd1 = size_t'(sd1);
    exp_sd2 = size_t'(sd2);
  endtask

  task automatic wait_push();
    int   cyc;
    logic seen;
    cyc = 0;
    seen = 1'b0;
    while (!seen && cyc < PUSH_TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
      seen = fifo_push_o;
    end
    if (!seen) begin
      $display("Timed out waiting for a descriptor push at %0t", $time);
      other_errs++;
      finish_run();
    end
  endtask

  // Starts the sequencer and checks every descriptor of the run, then done
  task automatic run_and_check(input string name);
    int  k, b, num, cyc, lat, base;
    time t0;
    base = push_count;
    num = 0;
    start_i = 1'b1;
    @(posedge clk_i);
    t0 = $time;
    #2;
    start_i = 1'b0;
    if (param_done_o) begin
      $display("%s: param_done_o was not cleared by start", name);
      other_errs++;
    end
    for (k = 0; k < cfg_chcol; k++) begin
      for (b = 0; b < cfg_batch; b++) begin
        expect_desc(k, b, num);
        wait_push();
        if (num == 0) begin
          lat = int'(($time + CLK_PERIOD / 2 - t0) / CLK_PERIOD);
          if (lat != FIRST_LATENCY) begin
            $display("ERR %0t fifo_push_o latency: got %0d, expected %0d",
                     $time, lat, FIRST_LATENCY);
            value_errs++;
          end
        end
        check_ptr("src_ptr_o", src_ptr_o, exp_src);
        check_ptr("dst_ptr_o", dst_ptr_o, exp_dst);
        check_inc("in_inc_d2_o", in_inc_d2_o, exp_inc);
        check_dim("n_zeros_top_o", n_zeros_top_o, exp_top);
        check_dim("n_zeros_bottom_o", n_zeros_bottom_o, exp_bottom);
        check_dim("n_zeros_left_o", n_zeros_left_o, exp_left);
        check_dim("n_zeros_right_o", n_zeros_right_o, exp_right);
        check_size("size_d1_o", size_d1_o, exp_sd1);
        check_size("size_d2_o", size_d2_o, exp_sd2);
        num++;
      end
    end
    cyc = 0;
    while (!param_done_o && cyc < DONE_TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!param_done_o) begin
      $display("%s: timed out waiting for param_done_o at %0t", name, $time);
      other_errs++;
      finish_run();
    end
    if (cyc != DONE_LATENCY) begin
      $display("ERR %0t param_done_o delay: got %0d, expected %0d", $time, cyc, DONE_LATENCY);
      value_errs++;
    end
    @(posedge clk_i);
    #2;
    repeat (8) @(posedge clk_i);
    #2;
    if (push_count - base != cfg_chcol * cfg_batch) begin
      $display("%s: expected %0d pushes, saw %0d", name, cfg_chcol * cfg_batch,
               push_count - base);
      other_errs++;
    end
    if (!param_done_o) begin
      $display("%s: param_done_o fell before the next start", name);
      other_errs++;
    end
  endtask

  task automatic test_reset_idle();
    repeat (20) begin
      @(negedge clk_i);
      if (fifo_push_o || param_done_o) begin
        $display("Push or done active after reset without a start at %0t", $time);
        other_errs++;
      end
    end
    if (push_count != 0) begin
      $display("Saw %0d pushes before any start", push_count);
      other_errs++;
    end
    @(posedge clk_i);
    #2;
  endtask

  task automatic test_no_padding();
    configure(32'h0001_0000, 32'h0008_0000, 6, 7, 3, 3, 2, 1,
              0, 0, 0, 0, 0, 0, 0, 0);
    run_and_check("no padding");
  endtask

  task automatic test_top_left_stride();
    configure(32'h0002_0000, 32'h0009_0000, 9, 10, 4, 3, 1, 1,
              3, 0, 2, 0, 0, 0, 1, 2);
    run_and_check("top left stride");
  endtask

  task automatic test_adaptive_batch();
    configure(32'h0003_0000, 32'h000a_0000, 5, 6, 2, 2, 2, 3,
              1, 2, 1, 1, 1, 1, 0, 1);
    run_and_check("adaptive batch");
  endtask

  task automatic test_random_stall();
    stall_en = 1'b1;
    configure(32'h0004_0000, 32'h000b_0000, 9, 10, 4, 3, 1, 2,
              3, 0, 2, 0, 0, 0, 1, 2);
    run_and_check("random stall");
    stall_en = 1'b0;
  endtask

  // A second start after done must restart from the new destination
  task automatic test_done_restart();
    if (!param_done_o) begin
      $display("param_done_o low before the restart");
      other_errs++;
    end
    cfg_dst = 32'h000c_0000;
    write_reg(DST_PTR, cfg_dst);
    run_and_check("done restart");
  endtask

  initial begin
    int cyc;
    cfg_we_i    = 1'b0;
    cfg_addr_i  = SRC_PTR;
    cfg_wdata_i = '0;
    start_i     = 1'b0;
    fifo_full_i = 1'b0;
    cyc = 0;
    while (!rst_ni && cyc < RESET_TIMEOUT) begin
      @(posedge clk_i);
      cyc++;
    end
    if (!rst_ni) begin
      $display("Reset was never released");
      other_errs++;
      finish_run();
    end
    #2;
    test_reset_idle();
    test_no_padding();
    test_top_left_stride();
    test_adaptive_batch();
    test_random_stall();
    test_done_restart();
    finish_run();
  end

endmodule

// ==== vlog.f ====
design/im2col_pkg.sv
design/im2col_cfg_regs.sv
design/im2col_loop_ctrl.sv
design/im2col_pad_calc.sv
design/im2col_addr_calc.sv
design/im2col_param_top.sv
testbench/tb_clk_gen.sv
testbench/tb_im2col_param.sv
